/* vlog.f */
verilog/evs_pkg.sv
verilog/guess_addr_gen.sv
verilog/mem_timer.sv
verilog/evs_store.sv
verilog/evs_control.sv
verilog/evs_finder_top.sv
tests/evs_finder_properties.sv
tests/evs_finder_tb.sv

/* tests/evs_finder_tb.sv */
`timescale 1ns/1ps

module evs_finder_tb;

  logic                clk;
  logic                reset;
  logic                cmd_start;
  evs_pkg::evs_cmd_t   cmd;
  evs_pkg::mem_req_t   mem_req;
  logic                mem_ack;
  evs_pkg::evs_index_t evs_rd_index;
  logic                op_done;
  evs_pkg::latency_t   op_timing;
  evs_pkg::evs_index_t evs_count;
  evs_pkg::cl_addr_t   evs_rd_data;

  // Memory model state
  evs_pkg::evs_cmd_t   cur_cmd;
  evs_pkg::cl_addr_t   last_addr;
  logic                search_mode;   // Target reads follow the guess rule
  int                  last_guess;
  int                  rand_lat;
  int                  rd_count;
  int                  wr_count;
  int                  cycle_cnt;
  int                  ack_cycle;
  int                  done_cycle;

  evs_finder_top evs_finder_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ================================================
  // Memory model
  // ================================================

  initial begin : memory_model
    int lat;
    evs_pkg::cl_addr_t stride;
    mem_ack = 1'b0;
    forever begin
      @(posedge clk);
      if (mem_req.valid) begin
        last_addr = mem_req.addr;
        stride = cur_cmd.large_page ? evs_pkg::GUESS_STRIDE_LARGE : evs_pkg::GUESS_STRIDE_SMALL;
        if (mem_req.write) begin
          wr_count++;
          lat = 4;
          if (search_mode && mem_req.addr != cur_cmd.adr_target) begin
            last_guess = int'((mem_req.addr - cur_cmd.adr_search) / stride);
          end
        end else begin
          rd_count++;
          if (search_mode && mem_req.addr == cur_cmd.adr_target) begin
            lat = (last_guess % 3 == 0) ? 40 : 10;  // Evicted by this guess
          end else begin
            lat = rand_lat;
          end
        end
        // Request cycle counts as cycle 1
        repeat (lat - 2) @(posedge clk);
        mem_ack <= 1'b1;
        ack_cycle = cycle_cnt;
        @(posedge clk);
        mem_ack <= 1'b0;
      end
    end
  end

  // ================================================
  // Checks
  // ================================================

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_latency(input evs_pkg::latency_t got, input evs_pkg::latency_t exp,
                               input string what);
    if (got !== exp) abort_run($sformatf("FAIL at %0t: %s is %0d, expected %0d",
                                         $time, what, got, exp));
  endtask

  task automatic check_addr(input evs_pkg::cl_addr_t got, input evs_pkg::cl_addr_t exp,
                            input string what);
    if (got !== exp) abort_run($sformatf("FAIL at %0t: %s is %0h, expected %0h",
                                         $time, what, got, exp));
  endtask

  task automatic check_count(input evs_pkg::evs_index_t got, input evs_pkg::evs_index_t exp,
                             input string what);
    if (got !== exp) abort_run($sformatf("FAIL at %0t: %s is %0d, expected %0d",
                                         $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) abort_run($sformatf("FAIL at %0t: %s is %b, expected %b",
                                         $time, what, got, exp));
  endtask

  // Stop at the first assertion failure of the bound checker
  always @(posedge clk) begin
    if (evs_finder_top_i.evs_finder_properties_i.violations != 0) begin
      abort_run("The bound property checker reported an assertion failure");
    end
  end

  // Start a command and wait for the finder to go busy and return idle
  task automatic run_op(input evs_pkg::evs_cmd_t c);
    int n;
    @(posedge clk);
    cur_cmd   = c;
    rd_count  = 0;
    wr_count  = 0;
    cmd       <= c;
    cmd_start <= 1'b1;
    @(posedge clk);
    cmd_start <= 1'b0;
    n = 0;
    while (op_done) begin
      @(posedge clk);
      n++;
      if (n > 4) abort_run("Timeout: op_done did not fall after cmd_start");
    end
    n = 0;
    while (!op_done) begin
      @(posedge clk);
      n++;
      if (n > 5000) abort_run("Timeout: the operation never returned to idle");
    end
    done_cycle = cycle_cnt;
  endtask

  task automatic read_slot(input evs_pkg::evs_index_t k, output evs_pkg::cl_addr_t data);
    @(posedge clk);
    evs_rd_index <= k;
    repeat (2) @(posedge clk);  // Registered readback
    data = evs_rd_data;
  endtask

  // ================================================
  // Directed tests
  // ================================================

  task automatic test_reset_state();
    repeat (10) begin
      @(posedge clk);
      check_flag(op_done, 1'b1, "op_done after reset");
      check_flag(mem_req.valid, 1'b0, "mem_req.valid after reset");
    end
  endtask

  task automatic test_single_read();
    evs_pkg::evs_cmd_t c;
    for (int i = 0; i < 4; i++) begin
      rand_lat     = $urandom_range(30, 5);
      c            = '0;
      c.op         = evs_pkg::OP_READ;
      c.adr_target = evs_pkg::cl_addr_t'({$urandom, $urandom});
      c.threshold  = 10'd25;
      run_op(c);
      check_count(evs_pkg::evs_index_t'(rd_count), 4'd1, "read requests");
      check_count(evs_pkg::evs_index_t'(wr_count), 4'd0, "write requests");
      check_addr(last_addr, c.adr_target, "read address");
      check_latency(op_timing, evs_pkg::latency_t'(rand_lat), "read latency");
    end
  endtask

  task automatic test_write_ops();
    evs_pkg::evs_cmd_t c;
    c            = '0;
    c.op         = evs_pkg::OP_WRITE_NONBL;
    c.adr_target = 42'h0_dead_bee0;
    run_op(c);
    check_count(evs_pkg::evs_index_t'(wr_count), 4'd1, "non-blocking write requests");
    check_addr(last_addr, c.adr_target, "non-blocking write address");
    check_latency(op_timing, 10'd4, "non-blocking write latency");
    c.op = evs_pkg::OP_WRITE_BLOCK;
    for (int w = 5; w >= 0; w -= 5) begin
      c.wait_cycles = evs_pkg::wait_t'(w);
      run_op(c);
      check_count(evs_pkg::evs_index_t'(wr_count), 4'd1, "blocking write requests");
      check_addr(last_addr, c.adr_target, "blocking write address");
      check_latency(op_timing, 10'd4, "blocking write latency");
      // Ack, then access_done, then w+1 wait cycles before idle
      check_latency(evs_pkg::latency_t'(done_cycle - ack_cycle - 1),
                    evs_pkg::latency_t'(w + 3), "ack to op_done gap");
    end
  endtask

  task automatic check_search(input evs_pkg::evs_cmd_t c);
    evs_pkg::cl_addr_t exp_addr [$];
    evs_pkg::cl_addr_t stride;
    evs_pkg::cl_addr_t got;
    evs_pkg::latency_t exp_last;
    stride   = c.large_page ? evs_pkg::GUESS_STRIDE_LARGE : evs_pkg::GUESS_STRIDE_SMALL;
    exp_last = '0;
    for (int idx = 0; idx <= int'(c.guess_limit); idx++) begin
      exp_last = (idx % 3 == 0) ? 10'd40 : 10'd10;
      if (idx % 3 == 0) begin
        exp_addr.push_back(c.adr_search + evs_pkg::cl_addr_t'(idx) * stride);
      end
      if (exp_addr.size() == int'(c.evs_wanted)) break;
    end
    search_mode = 1'b1;
    last_guess  = -1;
    run_op(c);
    search_mode = 1'b0;
    check_count(evs_count, evs_pkg::evs_index_t'(exp_addr.size()), "eviction-set size");
    check_latency(op_timing, exp_last, "last target read latency");
    foreach (exp_addr[k]) begin
      read_slot(evs_pkg::evs_index_t'(k), got);
      check_addr(got, exp_addr[k], $sformatf("eviction-set slot %0d", k));
    end
  endtask

  task automatic test_create_small();
    evs_pkg::evs_cmd_t c;
    c             = '0;
    c.op          = evs_pkg::OP_CREATE_EVS;
    c.adr_target  = 42'h3_0000_0040;
    c.adr_search  = 42'h1_0000_0000;
    c.threshold   = 10'd25;
    c.wait_cycles = 10'd2;
    c.evs_wanted  = 4'd4;
    c.guess_limit = 16'd100;
    check_search(c);
  endtask

  task automatic test_create_large();
    evs_pkg::evs_cmd_t c;
    c             = '0;
    c.op          = evs_pkg::OP_CREATE_EVS;
    c.adr_target  = 42'h3_0000_0040;
    c.adr_search  = 42'h2_0000_0100;
    c.threshold   = 10'd25;
    c.wait_cycles = 10'd1;
    c.evs_wanted  = 4'd8;
    c.guess_limit = 16'd5;   // Runs out of guesses first
    c.large_page  = 1'b1;
    check_search(c);
  endtask

  initial begin : main
    void'($urandom(32'he9ff1760));
    cycle_cnt    = 0;
    reset        = 1'b1;
    cmd_start    = 1'b0;
    cmd          = '0;
    evs_rd_index = '0;
    cur_cmd      = '0;
    search_mode  = 1'b0;
    last_guess   = -1;
    rand_lat     = 5;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_single_read();
    test_write_ops();
    test_create_small();
    test_create_large();
    if (evs_finder_top_i.evs_finder_properties_i.violations != 0) begin
      abort_run("The bound property checker reported assertion failures");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* tests/evs_finder_properties.sv */
`timescale 1ns/1ps

module evs_finder_properties (
  input logic              clk,
  input logic              reset,
  input logic              cmd_start,
  input evs_pkg::mem_req_t mem_req,
  input logic              mem_ack,
  input logic              op_done
);

  int   violations = 0;
  logic req_open;  // Request issued, ack not yet seen

  always_ff @(posedge clk) begin
    if (reset || mem_ack) begin
      req_open <= 1'b0;
    end else if (mem_req.valid) begin
      req_open <= 1'b1;
    end
  end

  // ================================================
  // Memory port
  // ================================================

  valid_pulse: assert property (@(posedge clk) disable iff (reset)
    mem_req.valid |=> !mem_req.valid)
    else begin
      $error("mem_req.valid held for more than one cycle");
      violations++;
    end

  single_outstanding: assert property (@(posedge clk) disable iff (reset)
    mem_req.valid |-> !req_open)
    else begin
      $error("New memory request issued before mem_ack");
      violations++;
    end

  // ================================================
  // Operation status
  // ================================================

  start_goes_busy: assert property (@(posedge clk) disable iff (reset)
    (cmd_start && op_done) |=> !op_done)
    else begin
      $error("op_done did not fall after cmd_start");
      violations++;
    end

  busy_until_ack: assert property (@(posedge clk) disable iff (reset)
    req_open |-> !op_done)
    else begin
      $error("op_done high with a request outstanding");
      violations++;
    end

endmodule

bind evs_finder_top evs_finder_properties evs_finder_properties_i (
  .clk, .reset, .cmd_start, .mem_req, .mem_ack, .op_done
);

/* verilog/evs_finder_top.sv */
`timescale 1ns/1ps

module evs_finder_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmd_start,
  input  evs_pkg::evs_cmd_t    cmd,
  output evs_pkg::mem_req_t    mem_req,
  input  logic                 mem_ack,
  input  evs_pkg::evs_index_t  evs_rd_index,
  output logic                 op_done,
  output evs_pkg::latency_t    op_timing,
  output evs_pkg::evs_index_t  evs_count,
  output evs_pkg::cl_addr_t    evs_rd_data
);

  // Controller to access timer
  logic              access_go;
  logic              access_write;
  evs_pkg::cl_addr_t access_addr;
  logic              access_done;
  logic              access_slow;

  // Search datapath
  logic              guess_next;
  logic              guess_restart;
  logic              guess_exhausted;
  evs_pkg::cl_addr_t guess_addr;
  logic              found;
  logic              clear;

  // ================================================
  // Blocks
  // ================================================

  evs_control evs_control_i (
    .clk, .reset, .cmd_start, .cmd,
    .access_done, .access_slow, .guess_exhausted, .guess_addr,
    .fill_count (evs_count),
    .access_go, .access_write, .guess_next, .guess_restart,
    .found, .clear, .access_addr, .op_done
  );

  guess_addr_gen guess_addr_gen_i (
    .clk, .reset, .cmd,
    .guess_restart, .guess_next,
    .guess_addr, .guess_exhausted
  );

  mem_timer mem_timer_i (
    .clk, .reset,
    .threshold (cmd.threshold),
    .access_go, .access_write, .access_addr,
    .mem_req, .mem_ack,
    .access_done, .access_slow, .op_timing
  );

  evs_store evs_store_i (
    .clk, .reset, .clear, .found, .guess_addr,
    .evs_rd_index,
    .fill_count (evs_count),
    .evs_rd_data
  );

endmodule

/* verilog/evs_control.sv */
`timescale 1ns/1ps

module evs_control (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 cmd_start,
  input  evs_pkg::evs_cmd_t    cmd,
  input  logic                 access_done,
  input  logic                 access_slow,
  input  logic                 guess_exhausted,
  input  evs_pkg::cl_addr_t    guess_addr,
  input  evs_pkg::evs_index_t  fill_count,
  output logic                 access_go,
  output logic                 access_write,
  output logic                 guess_next,
  output logic                 guess_restart,
  output logic                 found,
  output logic                 clear,
  output evs_pkg::cl_addr_t    access_addr,
  output logic                 op_done
);

  evs_pkg::state_t    state;
  evs_pkg::state_t    next_state;
  evs_pkg::evs_cmd_t  cmd_q;
  evs_pkg::addr_sel_t addr_sel;
  evs_pkg::wait_t     wait_cnt;
  logic               first_cycle;
  logic               is_access;
  logic               is_wait;
  logic               waited;
  logic               wanted_reached;

  always_ff @(posedge clk) begin
    if (state == evs_pkg::S_IDLE && cmd_start) begin
      cmd_q <= cmd;
    end
  end

  // ================================================
  // State classes and wait counter
  // ================================================

  always_comb begin
    is_access = 1'b0;
    is_wait   = 1'b0;
    case (state)
      evs_pkg::S_WR_TARGET, evs_pkg::S_WR_GUESS, evs_pkg::S_RD_TARGET,
      evs_pkg::S_WR_TEST, evs_pkg::S_WR_WTEST, evs_pkg::S_RD_TEST: is_access = 1'b1;
      evs_pkg::S_WR_TARGET_WAIT, evs_pkg::S_WR_GUESS_WAIT,
      evs_pkg::S_WAIT_WTEST: is_wait = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || !is_wait) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign waited = (wait_cnt == cmd_q.wait_cycles);  // wait_cycles+1 cycles in state

  // Marks the first cycle after any state change
  always_ff @(posedge clk) begin
    if (reset) begin
      first_cycle <= 1'b0;
    end else begin
      first_cycle <= (next_state != state);
    end
  end

  assign access_go = is_access && first_cycle;

  // Count after this find reaches the request
  assign wanted_reached =
    ({1'b0, fill_count} + 5'd1) >= {1'b0, cmd_q.evs_wanted};

  assign access_addr = (addr_sel == evs_pkg::ADDR_GUESS) ? guess_addr : cmd_q.adr_target;

  // ================================================
  // Mealy state machine
  // ================================================

  always_comb begin
    next_state    = state;
    addr_sel      = evs_pkg::ADDR_TARGET;
    access_write  = 1'b0;
    guess_next    = 1'b0;
    guess_restart = 1'b0;
    found         = 1'b0;
    clear         = 1'b0;
    op_done       = 1'b0;

    case (state)
      evs_pkg::S_IDLE: begin
        op_done = 1'b1;
        if (cmd_start) begin
          clear         = 1'b1;
          guess_restart = 1'b1;
          case (cmd.op)
            evs_pkg::OP_CREATE_EVS:  next_state = evs_pkg::S_WR_TARGET;
            evs_pkg::OP_WRITE_NONBL: next_state = evs_pkg::S_WR_TEST;
            evs_pkg::OP_WRITE_BLOCK: next_state = evs_pkg::S_WR_WTEST;
            evs_pkg::OP_READ:        next_state = evs_pkg::S_RD_TEST;
            default:                 next_state = evs_pkg::S_IDLE;
          endcase
        end
      end

      evs_pkg::S_WR_TARGET: begin
        access_write = 1'b1;
        if (access_done) next_state = evs_pkg::S_WR_TARGET_WAIT;
      end

      evs_pkg::S_WR_TARGET_WAIT: begin
        if (waited) next_state = evs_pkg::S_WR_GUESS;
      end

      evs_pkg::S_WR_GUESS: begin
        access_write = 1'b1;
        addr_sel     = evs_pkg::ADDR_GUESS;
        if (access_done) next_state = evs_pkg::S_WR_GUESS_WAIT;
      end

      evs_pkg::S_WR_GUESS_WAIT: begin
        if (waited) next_state = evs_pkg::S_RD_TARGET;
      end

      evs_pkg::S_RD_TARGET: begin
        if (access_done) begin
          found = access_slow;  // Guess evicted the target
          if ((access_slow && wanted_reached) || guess_exhausted) begin
            next_state = evs_pkg::S_IDLE;
          end else begin
            guess_next = 1'b1;
            next_state = access_slow ? evs_pkg::S_WR_TARGET : evs_pkg::S_WR_GUESS;
          end
        end
      end

      evs_pkg::S_WR_TEST: begin
        access_write = 1'b1;
        if (access_done) next_state = evs_pkg::S_IDLE;
      end

      evs_pkg::S_WR_WTEST: begin
        access_write = 1'b1;
        if (access_done) next_state = evs_pkg::S_WAIT_WTEST;
      end

      evs_pkg::S_WAIT_WTEST: begin
        if (waited) next_state = evs_pkg::S_IDLE;
      end

      evs_pkg::S_RD_TEST: begin
        if (access_done) next_state = evs_pkg::S_IDLE;
      end

      default: next_state = evs_pkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= evs_pkg::S_IDLE;
    end else begin
      state <= next_state;
    end
  end

endmodule

/* verilog/evs_store.sv */
`timescale 1ns/1ps

module evs_store (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 clear,
  input  logic                 found,
  input  evs_pkg::cl_addr_t    guess_addr,
  input  evs_pkg::evs_index_t  evs_rd_index,
  output evs_pkg::evs_index_t  fill_count,
  output evs_pkg::cl_addr_t    evs_rd_data
);

  // Found addresses
  evs_pkg::cl_addr_t evs_mem [evs_pkg::EVS_SIZE];

  // ================================================
  // Fill side
  // ================================================

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      fill_count <= '0;
    end else if (found) begin
      fill_count <= fill_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      evs_mem[fill_count] <= guess_addr;  // Next free slot
    end
  end

  // ================================================
  // Host readback
  // ================================================

  // Registered, one cycle behind the index
  always_ff @(posedge clk) begin
    evs_rd_data <= evs_mem[evs_rd_index];
  end

endmodule

/* verilog/mem_timer.sv */
`timescale 1ns/1ps

module mem_timer (
  input  logic                clk,
  input  logic                reset,
  input  evs_pkg::latency_t   threshold,
  input  logic                access_go,
  input  logic                access_write,
  input  evs_pkg::cl_addr_t   access_addr,
  output evs_pkg::mem_req_t   mem_req,
  input  logic                mem_ack,
  output logic                access_done,
  output logic                access_slow,
  output evs_pkg::latency_t   op_timing
);

  logic              req_valid;
  logic              req_write;
  evs_pkg::cl_addr_t req_addr;
  logic              busy;
  logic              ack_seen;
  evs_pkg::latency_t lat_cnt;

  // ================================================
  // Request register
  // ================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= access_go;  // One-cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (access_go) begin
      req_write <= access_write;
      req_addr  <= access_addr;
    end
  end

  assign mem_req = '{valid: req_valid, write: req_write, addr: req_addr};

  // ================================================
  // Latency measurement
  // ================================================

  assign ack_seen = busy && mem_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (access_go) begin
      busy <= 1'b1;
    end else if (mem_ack) begin
      busy <= 1'b0;
    end
  end

  // Request cycle counts as 1, ack cycle included
  always_ff @(posedge clk) begin
    if (access_go) begin
      lat_cnt <= evs_pkg::latency_t'(1);
    end else if (busy && lat_cnt != '1) begin
      lat_cnt <= lat_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      access_done <= 1'b0;
      op_timing   <= '0;
    end else begin
      access_done <= ack_seen;
      if (ack_seen) op_timing <= lat_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (ack_seen) access_slow <= (lat_cnt >= threshold);  // Evicted target
  end

endmodule

/* verilog/guess_addr_gen.sv */
`timescale 1ns/1ps

module guess_addr_gen (
  input  logic                clk,
  input  logic                reset,
  input  evs_pkg::evs_cmd_t   cmd,
  input  logic                guess_restart,
  input  logic                guess_next,
  output evs_pkg::cl_addr_t   guess_addr,
  output logic                guess_exhausted
);

  evs_pkg::guess_count_t guess_cnt;
  evs_pkg::guess_count_t guess_limit_q;
  evs_pkg::cl_addr_t     adr_search_q;
  logic                  large_page_q;
  evs_pkg::cl_addr_t     guess_offset;

  // Guess counter
  always_ff @(posedge clk) begin
    if (reset || guess_restart) begin
      guess_cnt <= '0;
    end else if (guess_next) begin
      guess_cnt <= guess_cnt + 1'b1;
    end
  end

  // Search parameters held for the whole operation
  always_ff @(posedge clk) begin
    if (guess_restart) begin
      adr_search_q  <= cmd.adr_search;
      large_page_q  <= cmd.large_page;
      guess_limit_q <= cmd.guess_limit;
    end
  end

  assign guess_offset = large_page_q ?
    evs_pkg::cl_addr_t'(guess_cnt) * evs_pkg::GUESS_STRIDE_LARGE :
    evs_pkg::cl_addr_t'(guess_cnt) * evs_pkg::GUESS_STRIDE_SMALL;

  assign guess_addr      = adr_search_q + guess_offset;
  assign guess_exhausted = (guess_cnt == guess_limit_q);  // Last allowed guess

endmodule

/* verilog/evs_pkg.sv */
package evs_pkg;

  // ================================================
  // Widths
  // ================================================

  localparam int CL_ADDR_W     = 42;
  localparam int LATENCY_W     = 10;  // Saturating latency counter
  localparam int WAIT_W        = 10;
  localparam int EVS_INDEX_W   = 4;
  localparam int GUESS_COUNT_W = 16;

  typedef logic [CL_ADDR_W-1:0]     cl_addr_t;      // Cache-line address
  typedef logic [LATENCY_W-1:0]     latency_t;      // Cycles, also the threshold
  typedef logic [WAIT_W-1:0]        wait_t;
  typedef logic [EVS_INDEX_W-1:0]   evs_index_t;    // Slot index and count
  typedef logic [GUESS_COUNT_W-1:0] guess_count_t;

  localparam int EVS_SIZE = 16;

  // Guess step in cache lines
  localparam cl_addr_t GUESS_STRIDE_SMALL = 42'd32;
  localparam cl_addr_t GUESS_STRIDE_LARGE = 42'd1;

  // ================================================
  // Opcodes and state machine
  // ================================================

  typedef enum logic [2:0] {
    OP_CREATE_EVS  = 3'd0,
    OP_WRITE_NONBL = 3'd1,
    OP_WRITE_BLOCK = 3'd2,
    OP_READ        = 3'd3
  } op_code_t;

  typedef enum logic [1:0] {
    ADDR_TARGET = 2'd0,
    ADDR_GUESS  = 2'd1
  } addr_sel_t;

  typedef enum logic [3:0] {
    S_IDLE,
    S_WR_TARGET,       // Eviction-set search loop
    S_WR_TARGET_WAIT,
    S_WR_GUESS,
    S_WR_GUESS_WAIT,
    S_RD_TARGET,
    S_WR_TEST,         // Single accesses
    S_WR_WTEST,
    S_WAIT_WTEST,
    S_RD_TEST
  } state_t;

  // Host command, sampled at cmd_start
  typedef struct packed {
    op_code_t     op;
    cl_addr_t     adr_target;
    cl_addr_t     adr_search;
    latency_t     threshold;
    wait_t        wait_cycles;
    evs_index_t   evs_wanted;
    guess_count_t guess_limit;
    logic         large_page;
  } evs_cmd_t;

  typedef struct packed {
    logic     valid;
    logic     write;
    cl_addr_t addr;
  } mem_req_t;

endpackage
